/* id_stage.f */
+incdir+design
design/mips_isa_pkg.sv
design/id_pipe_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/operand_bypass.sv
design/branch_resolve.sv
design/stage_ctrl.sv
design/id_stage.sv
verification/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - include_dirs:
      - design
    files:
      - design/mips_isa_pkg.sv
      - design/id_pipe_pkg.sv
      - design/inst_decoder.sv
      - design/reg_file.sv
      - design/operand_bypass.sv
      - design/branch_resolve.sv
      - design/stage_ctrl.sv
      - design/id_stage.sv
      - target: test
        files:
          - verification/tb_id_stage.sv

/* verification/tb_id_stage.sv */
`include "mips_isa_consts.svh"

module tb_id_stage;
  import mips_isa_pkg::*;
  import id_pipe_pkg::*;

  logic        clk;
  logic        reset;
  logic        flush;
  logic        in_valid;
  fetch_bus_t  in_bus;
  logic        allowin;
  logic        out_valid;
  decode_bus_t out_bus;
  logic        exec_allowin;
  br_bus_t     br_bus;
  wb_bus_t     wb_bus;
  exe_fwd_t    exe_fwd;
  fwd_t        mem_fwd;

  int    errors;   // value mismatches
  int    timeouts; // waits that ran out
  word_t v5;       // contents of $5
  word_t v6;       // contents of $6, never equal to v5

  id_stage id_stage_inst (
    .clk, .reset, .flush,
    .in_valid, .in_bus, .allowin,
    .out_valid, .out_bus, .exec_allowin,
    .br_bus, .wb_bus, .exe_fwd, .mem_fwd
  );

  always #2 clk = ~clk; // period 4

  function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
                                   input reg_addr_t rd, input logic [4:0] sa,
                                   input funct_t fn);
    return {`OP_SPECIAL, rs, rt, rd, sa, fn};
  endfunction

  function automatic word_t i_type(input opcode_t op, input reg_addr_t rs,
                                   input reg_addr_t rt, input imm_t imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t j_type(input opcode_t op, input logic [25:0] index);
    return {op, index};
  endfunction

  // pc+4 plus word offset
  function automatic word_t branch_target(input word_t pc, input imm_t imm);
    int offset;
    offset = $signed(imm) * 4; // bytes from the delay slot
    return pc + 32'd4 + word_t'(offset);
  endfunction

  // region of the delay slot
  function automatic word_t jump_target(input word_t pc, input logic [25:0] index);
    word_t seq;
    seq = pc + 32'd4;
    return (seq & 32'hf000_0000) | (word_t'(index) * 4);
  endfunction

  task automatic check_value(input string name,
                             input logic [$bits(decode_bus_t)-1:0] got,
                             input logic [$bits(decode_bus_t)-1:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("error %s got %0h expected %0h", name, got, exp);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1; // drive point
  endtask

  task automatic clear_sources();
    exe_fwd = '0;
    mem_fwd = '0;
    wb_bus  = '0;
  endtask

  task automatic set_exe(input reg_addr_t dest, input word_t result, input logic is_load);
    exe_fwd.fwd.valid  = 1'b1;
    exe_fwd.fwd.gr_we  = 1'b1;
    exe_fwd.fwd.dest   = dest;
    exe_fwd.fwd.result = result;
    exe_fwd.is_load    = is_load;
  endtask

  task automatic set_mem(input reg_addr_t dest, input word_t result);
    mem_fwd.valid  = 1'b1;
    mem_fwd.gr_we  = 1'b1;
    mem_fwd.dest   = dest;
    mem_fwd.result = result;
  endtask

  task automatic set_wb(input reg_addr_t addr, input word_t data);
    wb_bus.we    = 1'b1;
    wb_bus.waddr = addr;
    wb_bus.wdata = data;
  endtask

  task automatic write_reg(input reg_addr_t addr, input word_t data);
    next_cycle();
    set_wb(addr, data);
    next_cycle(); // written at this edge
    wb_bus.we = 1'b0;
  endtask

  // offer one item, return one cycle after acceptance
  task automatic issue(input word_t pc, input word_t inst);
    int n;
    n = 0;
    next_cycle();
    in_valid    = 1'b1;
    in_bus.pc   = pc;
    in_bus.inst = inst;
    #1;
    while (!allowin && n < 16) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!allowin) begin
      timeouts++;
      $display("timeout: allowin stayed low, item at pc %0h not accepted", pc);
    end
    next_cycle();
    in_valid = 1'b0;
  endtask

  task automatic wait_out_valid();
    int n;
    n = 0;
    #1;
    while (!out_valid && n < 16) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!out_valid) begin
      timeouts++;
      $display("timeout: out_valid never rose after an item was accepted");
    end
  endtask

  task automatic reset_state();
    #1;
    check_value("out_valid", out_valid, 1'b0);
    check_value("br_bus.taken", br_bus.taken, 1'b0);
    check_value("allowin", allowin, 1'b1);
  endtask

  task automatic alu_decode();
    v5 = $urandom();
    v6 = $urandom();
    if (v6 == v5) begin
      v6 = ~v5;
    end
    write_reg(5'd5, v5);
    write_reg(5'd6, v6);
    issue(32'h0040_0000, r_type(5'd5, 5'd6, 5'd7, 5'd0, `FN_ADDU));
    wait_out_valid();
    check_value("out_bus.rs_value", out_bus.rs_value, v5); // from the file
    check_value("out_bus.rt_value", out_bus.rt_value, v6);
    check_value("ctrl.alu_op", out_bus.ctrl.alu_op, 1 << `ALU_ADD);
    check_value("ctrl.dest", out_bus.ctrl.dest, 5'd7); // rd
    check_value("ctrl.gr_we", out_bus.ctrl.gr_we, 1'b1);
    check_value("ctrl.reserved", out_bus.ctrl.reserved, 1'b0);
    issue(32'h0040_0004, i_type(`OP_ORI, 5'd6, 5'd8, 16'h00ff));
    wait_out_valid();
    check_value("out_bus.rs_value", out_bus.rs_value, v6);
    check_value("out_bus.imm", out_bus.imm, 16'h00ff);
    check_value("ctrl.alu_op", out_bus.ctrl.alu_op, 1 << `ALU_OR);
    check_value("ctrl.dest", out_bus.ctrl.dest, 5'd8); // rt for imm forms
    check_value("ctrl.gr_we", out_bus.ctrl.gr_we, 1'b1);
    check_value("ctrl.src2_is_zimm", out_bus.ctrl.src2_is_zimm, 1'b1);
    issue(32'h0040_0008, {6'h3f, 26'h0}); // unused opcode
    wait_out_valid();
    check_value("ctrl.reserved", out_bus.ctrl.reserved, 1'b1);
    check_value("ctrl.gr_we", out_bus.ctrl.gr_we, 1'b0);
  endtask

  task automatic bypass_priority();
    next_cycle();
    exec_allowin = 1'b0; // item stays while sources change
    issue(32'h0040_1000, r_type(5'd10, 5'd11, 5'd9, 5'd0, `FN_ADDU));
    wait_out_valid();
    next_cycle();
    set_exe(5'd10, 32'haaaa_0001, 1'b0);
    set_mem(5'd10, 32'hbbbb_0002);
    set_wb(5'd10, 32'hcccc_0003);
    #1;
    check_value("out_bus.rs_value", out_bus.rs_value, 32'haaaa_0001); // execute first
    next_cycle();
    exe_fwd.fwd.valid = 1'b0;
    #1;
    check_value("out_bus.rs_value", out_bus.rs_value, 32'hbbbb_0002); // then memory
    next_cycle();
    mem_fwd.valid = 1'b0;
    set_wb(5'd10, 32'hdddd_0004); // file still holds the older write
    #1;
    check_value("out_bus.rs_value", out_bus.rs_value, 32'hdddd_0004); // then write-back
    next_cycle();
    exec_allowin = 1'b1;
    set_exe(5'd0, 32'h1111_1111, 1'b0); // all aimed at $zero
    set_mem(5'd0, 32'h2222_2222);
    set_wb(5'd0, 32'h3333_3333);
    issue(32'h0040_1004, r_type(5'd0, 5'd11, 5'd9, 5'd0, `FN_ADDU));
    wait_out_valid();
    check_value("out_bus.rs_value", out_bus.rs_value, 32'h0);
  endtask

  task automatic load_use_stall();
    next_cycle();
    clear_sources();
    set_exe(5'd13, 32'h1357_9bdf, 1'b1); // lw to $13 in execute
    issue(32'h0040_3000, r_type(5'd13, 5'd14, 5'd12, 5'd0, `FN_ADDU));
    repeat (3) begin
      #1;
      check_value("out_valid", out_valid, 1'b0);
      check_value("allowin", allowin, 1'b0);
      check_value("br_bus.taken", br_bus.taken, 1'b0);
      next_cycle();
    end
    exe_fwd.is_load = 1'b0; // data now ready
    wait_out_valid();
    check_value("out_bus.pc", out_bus.pc, 32'h0040_3000);
    check_value("ctrl.dest", out_bus.ctrl.dest, 5'd12);
    check_value("ctrl.alu_op", out_bus.ctrl.alu_op, 1 << `ALU_ADD);
    check_value("out_bus.rs_value", out_bus.rs_value, 32'h1357_9bdf);
  endtask

  task automatic branch_and_jump();
    next_cycle();
    clear_sources();
    issue(32'h0040_1000, i_type(`OP_BEQ, 5'd5, 5'd5, 16'hfff0)); // backward
    wait_out_valid();
    check_value("br_bus.taken", br_bus.taken, 1'b1);
    check_value("br_bus.target", br_bus.target, branch_target(32'h0040_1000, 16'hfff0));
    issue(32'h0040_1100, i_type(`OP_BEQ, 5'd5, 5'd6, 16'h0010));
    wait_out_valid();
    check_value("br_bus.taken", br_bus.taken, 1'b0);
    check_value("br_bus.target", br_bus.target, branch_target(32'h0040_1100, 16'h0010));
    issue(32'h2fff_fffc, j_type(`OP_J, 26'h012_3456)); // slot in next region
    wait_out_valid();
    check_value("br_bus.taken", br_bus.taken, 1'b1);
    check_value("br_bus.target", br_bus.target, jump_target(32'h2fff_fffc, 26'h012_3456));
    issue(32'h0040_4000, r_type(5'd5, 5'd0, 5'd0, 5'd0, `FN_JR));
    wait_out_valid();
    check_value("br_bus.taken", br_bus.taken, 1'b1);
    check_value("br_bus.target", br_bus.target, v5);
    issue(32'h0040_5000, j_type(`OP_JAL, 26'h000_0040));
    wait_out_valid();
    check_value("br_bus.taken", br_bus.taken, 1'b1);
    check_value("br_bus.target", br_bus.target, jump_target(32'h0040_5000, 26'h000_0040));
    check_value("ctrl.dest", out_bus.ctrl.dest, 5'd31);
    check_value("ctrl.src2_is_8", out_bus.ctrl.src2_is_8, 1'b1);
    check_value("ctrl.gr_we", out_bus.ctrl.gr_we, 1'b1);
  endtask

  task automatic backpressure_flush();
    decode_bus_t snap;
    next_cycle();
    exec_allowin = 1'b0; // execute busy
    issue(32'h0040_6000, r_type(5'd5, 5'd6, 5'd3, 5'd0, `FN_SUBU));
    wait_out_valid();
    snap = out_bus;
    check_value("out_bus.pc", snap.pc, 32'h0040_6000);
    check_value("out_bus.rs_value", snap.rs_value, v5);
    check_value("out_bus.rt_value", snap.rt_value, v6);
    check_value("ctrl.alu_op", snap.ctrl.alu_op, 1 << `ALU_SUB);
    check_value("ctrl.dest", snap.ctrl.dest, 5'd3);
    next_cycle();
    in_valid    = 1'b1; // next item offered while execute is busy
    in_bus.pc   = 32'h0040_6004;
    in_bus.inst = r_type(5'd6, 5'd5, 5'd4, 5'd0, `FN_XOR);
    repeat (4) begin
      next_cycle();
      #1;
      check_value("out_bus", out_bus, snap);
      check_value("allowin", allowin, 1'b0);
      check_value("out_valid", out_valid, 1'b1);
    end
    next_cycle();
    in_valid = 1'b0;
    flush    = 1'b1;
    next_cycle(); // valid cleared here
    flush = 1'b0;
    #1;
    check_value("out_valid", out_valid, 1'b0);
    check_value("allowin", allowin, 1'b1);
    next_cycle();
    exec_allowin = 1'b1;
  endtask

  initial begin
    errors       = 0;
    timeouts     = 0;
    clk          = 1'b0;
    reset        = 1'b1;
    flush        = 1'b0;
    in_valid     = 1'b0;
    in_bus       = '0;
    exec_allowin = 1'b1;
    wb_bus       = '0;
    exe_fwd      = '0;
    mem_fwd      = '0;
    v5           = $urandom(81); // seeds the generator
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    reset_state();
    alu_decode();
    bypass_priority();
    load_use_stall();
    branch_and_jump();
    backpressure_flush();
    $display("value mismatches: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* design/id_stage.sv */
`include "mips_isa_consts.svh"

module id_stage (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     flush,
  input  logic                     in_valid,
  input  id_pipe_pkg::fetch_bus_t  in_bus,
  output logic                     allowin,
  output logic                     out_valid,
  output id_pipe_pkg::decode_bus_t out_bus,
  input  logic                     exec_allowin,
  output id_pipe_pkg::br_bus_t     br_bus,
  input  id_pipe_pkg::wb_bus_t     wb_bus,
  input  id_pipe_pkg::exe_fwd_t    exe_fwd,
  input  id_pipe_pkg::fwd_t        mem_fwd
);
  import mips_isa_pkg::*;
  import id_pipe_pkg::*;

  fetch_bus_t                held;      // instruction register
  ctrl_t                     ctrl;
  reg_addr_t [`NUM_SRC-1:0]  src_addr;  // rs, rt
  word_t     [`NUM_SRC-1:0]  file_data; // raw file reads
  word_t     [`NUM_SRC-1:0]  src_value; // after bypass
  imm_t                      imm;
  logic      [25:0]          jump_index;
  logic is_beq, is_bne, is_bgez, is_bgtz, is_blez, is_bltz;
  logic is_link_branch, is_j, is_jal, is_jr;
  logic uses_rt;

  stage_ctrl stage_ctrl_inst (
    .clk, .reset, .flush,
    .in_valid, .in_bus, .allowin,
    .exec_allowin, .out_valid, .held,
    .src_addr, .uses_rt, .exe_fwd
  );

  inst_decoder inst_decoder_inst (
    .inst (held.inst),
    .ctrl, .src_addr, .imm, .jump_index,
    .is_beq, .is_bne, .is_bgez, .is_bgtz, .is_blez, .is_bltz,
    .is_link_branch, .is_j, .is_jal, .is_jr,
    .uses_rt
  );

  reg_file reg_file_inst (
    .clk,
    .raddr (src_addr),
    .rdata (file_data),
    .wb    (wb_bus)
  );

  for (genvar i = 0; i < `NUM_SRC; i++) begin : g_bypass
    operand_bypass operand_bypass_inst (
      .addr      (src_addr[i]),
      .file_data (file_data[i]),
      .exe_fwd   (exe_fwd),
      .mem_fwd   (mem_fwd),
      .wb        (wb_bus),
      .value     (src_value[i])
    );
  end

  branch_resolve branch_resolve_inst (
    .valid    (out_valid), // no redirect while stalled
    .pc       (held.pc),
    .imm, .jump_index,
    .is_beq, .is_bne, .is_bgez, .is_bgtz, .is_blez, .is_bltz,
    .is_link_branch, .is_j, .is_jal, .is_jr,
    .rs_value (src_value[0]),
    .rt_value (src_value[1]),
    .br       (br_bus)
  );

  assign out_bus = '{ctrl:     ctrl,
                     imm:      imm,
                     rs_value: src_value[0],
                     rt_value: src_value[1],
                     pc:       held.pc};

endmodule

/* design/stage_ctrl.sv */
`include "mips_isa_consts.svh"

module stage_ctrl (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   flush,
  input  logic                                   in_valid,
  input  id_pipe_pkg::fetch_bus_t                in_bus,
  output logic                                   allowin,
  input  logic                                   exec_allowin,
  output logic                                   out_valid,
  output id_pipe_pkg::fetch_bus_t                held,
  input  mips_isa_pkg::reg_addr_t [`NUM_SRC-1:0] src_addr,
  input  logic                                   uses_rt,
  input  id_pipe_pkg::exe_fwd_t                  exe_fwd
);

  logic valid;        // stage holds an item
  logic load_pending; // load in execute, data only after mem
  logic rs_hazard;
  logic rt_hazard;
  logic ready_go;

  assign load_pending = exe_fwd.fwd.valid & exe_fwd.fwd.gr_we & exe_fwd.is_load &
                        (exe_fwd.fwd.dest != '0);
  assign rs_hazard    = (exe_fwd.fwd.dest == src_addr[0]);
  assign rt_hazard    = uses_rt & (exe_fwd.fwd.dest == src_addr[1]);
  assign ready_go     = ~(load_pending & (rs_hazard | rt_hazard)); // low on load-use

  assign out_valid = valid & ready_go;
  assign allowin   = ~valid | (ready_go & exec_allowin); // empty, or leaving now

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      valid <= 1'b0;
    end else if (allowin) begin
      valid <= in_valid;
    end
  end

  // instruction register, held through stalls
  always_ff @(posedge clk) begin
    if (in_valid && allowin) begin
      held <= in_bus;
    end
  end

endmodule

/* design/branch_resolve.sv */
module branch_resolve (
  input  logic                valid,
  input  mips_isa_pkg::word_t pc,
  input  mips_isa_pkg::imm_t  imm,
  input  logic [25:0]         jump_index,
  input  logic                is_beq,
  input  logic                is_bne,
  input  logic                is_bgez,
  input  logic                is_bgtz,
  input  logic                is_blez,
  input  logic                is_bltz,
  input  logic                is_link_branch,
  input  logic                is_j,
  input  logic                is_jal,
  input  logic                is_jr,
  input  mips_isa_pkg::word_t rs_value,
  input  mips_isa_pkg::word_t rt_value,
  output id_pipe_pkg::br_bus_t br
);
  import mips_isa_pkg::*;

  word_t seq_pc;     // pc of delay slot
  word_t br_offset;
  logic  rs_eq_rt;
  logic  rs_ge_z;
  logic  rs_le_z;
  logic  cond_branch;
  logic  cond_taken;

  assign seq_pc    = pc + 32'd4;
  assign br_offset = {{14{imm[15]}}, imm, 2'b00}; // word offset, sign-extended
  assign rs_eq_rt  = (rs_value == rt_value);
  assign rs_ge_z   = ~rs_value[31];
  assign rs_le_z   = rs_value[31] | (rs_value == '0);

  assign cond_branch = is_beq | is_bne | is_bgez | is_bgtz | is_blez | is_bltz |
                       is_link_branch;
  assign cond_taken  = (is_beq & rs_eq_rt) | (is_bne & ~rs_eq_rt) |
                       (is_bgez & rs_ge_z) | (is_bltz & ~rs_ge_z) |
                       (is_bgtz & ~rs_le_z) | (is_blez & rs_le_z);

  always_comb begin
    br.taken = valid & (cond_taken | is_j | is_jal | is_jr); // empty stage never redirects
    if (cond_branch) begin
      br.target = seq_pc + br_offset;
    end else if (is_jr) begin
      br.target = rs_value;
    end else begin
      br.target = {seq_pc[31:28], jump_index, 2'b00}; // 256MB region of slot
    end
  end

endmodule

/* design/operand_bypass.sv */
module operand_bypass (
  input  mips_isa_pkg::reg_addr_t addr,
  input  mips_isa_pkg::word_t     file_data,
  input  id_pipe_pkg::exe_fwd_t   exe_fwd,
  input  id_pipe_pkg::fwd_t       mem_fwd,
  input  id_pipe_pkg::wb_bus_t    wb,
  output mips_isa_pkg::word_t     value
);

  logic live;    // $zero is never bypassed
  logic exe_hit;
  logic mem_hit;
  logic wb_hit;

  assign live    = (addr != '0);
  assign exe_hit = live & exe_fwd.fwd.valid & exe_fwd.fwd.gr_we & (exe_fwd.fwd.dest == addr);
  assign mem_hit = live & mem_fwd.valid & mem_fwd.gr_we & (mem_fwd.dest == addr);
  assign wb_hit  = live & wb.we & (wb.waddr == addr); // written this cycle, file not yet

  // youngest producer wins
  always_comb begin
    if (exe_hit) begin
      value = exe_fwd.fwd.result;
    end else if (mem_hit) begin
      value = mem_fwd.result;
    end else if (wb_hit) begin
      value = wb.wdata;
    end else begin
      value = file_data;
    end
  end

endmodule

/* design/reg_file.sv */
`include "mips_isa_consts.svh"

module reg_file (
  input  logic                                   clk,
  input  mips_isa_pkg::reg_addr_t [`NUM_SRC-1:0] raddr,
  output mips_isa_pkg::word_t     [`NUM_SRC-1:0] rdata,
  input  id_pipe_pkg::wb_bus_t                   wb
);
  import mips_isa_pkg::*;

  word_t regs [`REG_COUNT]; // entry 0 never written

  always_ff @(posedge clk) begin
    if (wb.we && wb.waddr != '0) begin
      regs[wb.waddr] <= wb.wdata;
    end
  end

  // async read, $zero forced
  always_comb begin
    for (int i = 0; i < `NUM_SRC; i++) begin
      rdata[i] = (raddr[i] == '0) ? '0 : regs[raddr[i]];
    end
  end

endmodule

/* design/inst_decoder.sv */
`include "mips_isa_consts.svh"

module inst_decoder (
  input  mips_isa_pkg::word_t                    inst,
  output id_pipe_pkg::ctrl_t                     ctrl,
  output mips_isa_pkg::reg_addr_t [`NUM_SRC-1:0] src_addr, // [0] rs, [1] rt
  output mips_isa_pkg::imm_t                     imm,
  output logic [25:0]                            jump_index,
  output logic                                   is_beq,
  output logic                                   is_bne,
  output logic                                   is_bgez,        // also bgezal
  output logic                                   is_bgtz,
  output logic                                   is_blez,
  output logic                                   is_bltz,        // also bltzal
  output logic                                   is_link_branch, // bgezal, bltzal
  output logic                                   is_j,
  output logic                                   is_jal,
  output logic                                   is_jr,          // jr and jalr
  output logic                                   uses_rt
);
  import mips_isa_pkg::*;

  opcode_t   op;
  funct_t    fn;
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  reg_addr_t sa;
  logic      special;
  logic      regimm;
  logic      sa_zero;
  logic      rs_zero;
  logic inst_add, inst_addu, inst_sub, inst_subu, inst_slt, inst_sltu;
  logic inst_and, inst_or, inst_xor, inst_nor;
  logic inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
  logic inst_addi, inst_addiu, inst_slti, inst_sltiu;
  logic inst_andi, inst_ori, inst_xori, inst_lui;
  logic inst_lw, inst_sw;
  logic inst_bgez, inst_bltz, inst_bgezal, inst_bltzal;
  logic inst_jr_only, inst_jalr;
  logic r_alu, i_alu, plain_branch, link_r31, known;

  assign op         = inst[31:26];
  assign rs         = inst[25:21];
  assign rt         = inst[20:16];
  assign rd         = inst[15:11];
  assign sa         = inst[10:6];
  assign fn         = inst[5:0];
  assign imm        = inst[15:0];
  assign jump_index = inst[25:0];
  assign src_addr   = {rt, rs};

  assign special = (op == `OP_SPECIAL);
  assign regimm  = (op == `OP_REGIMM);
  assign sa_zero = (sa == '0);
  assign rs_zero = (rs == '0);

  // three-register forms require sa clear, constant shifts require rs clear
  assign inst_add   = special & sa_zero & (fn == `FN_ADD);
  assign inst_addu  = special & sa_zero & (fn == `FN_ADDU);
  assign inst_sub   = special & sa_zero & (fn == `FN_SUB);
  assign inst_subu  = special & sa_zero & (fn == `FN_SUBU);
  assign inst_slt   = special & sa_zero & (fn == `FN_SLT);
  assign inst_sltu  = special & sa_zero & (fn == `FN_SLTU);
  assign inst_and   = special & sa_zero & (fn == `FN_AND);
  assign inst_or    = special & sa_zero & (fn == `FN_OR);
  assign inst_xor   = special & sa_zero & (fn == `FN_XOR);
  assign inst_nor   = special & sa_zero & (fn == `FN_NOR);
  assign inst_sllv  = special & sa_zero & (fn == `FN_SLLV);
  assign inst_srlv  = special & sa_zero & (fn == `FN_SRLV);
  assign inst_srav  = special & sa_zero & (fn == `FN_SRAV);
  assign inst_sll   = special & rs_zero & (fn == `FN_SLL);
  assign inst_srl   = special & rs_zero & (fn == `FN_SRL);
  assign inst_sra   = special & rs_zero & (fn == `FN_SRA);
  assign inst_jr_only = special & sa_zero & (rt == '0) & (rd == '0) & (fn == `FN_JR);
  assign inst_jalr  = special & sa_zero & (rt == '0) & (fn == `FN_JALR); // link reg in rd

  assign inst_addi  = (op == `OP_ADDI);
  assign inst_addiu = (op == `OP_ADDIU);
  assign inst_slti  = (op == `OP_SLTI);
  assign inst_sltiu = (op == `OP_SLTIU);
  assign inst_andi  = (op == `OP_ANDI);
  assign inst_ori   = (op == `OP_ORI);
  assign inst_xori  = (op == `OP_XORI);
  assign inst_lui   = (op == `OP_LUI) & rs_zero;
  assign inst_lw    = (op == `OP_LW);
  assign inst_sw    = (op == `OP_SW);

  assign inst_bltz   = regimm & (rt == `RI_BLTZ);
  assign inst_bgez   = regimm & (rt == `RI_BGEZ);
  assign inst_bltzal = regimm & (rt == `RI_BLTZAL);
  assign inst_bgezal = regimm & (rt == `RI_BGEZAL);

  assign is_beq         = (op == `OP_BEQ);
  assign is_bne         = (op == `OP_BNE);
  assign is_bgtz        = (op == `OP_BGTZ) & (rt == '0);
  assign is_blez        = (op == `OP_BLEZ) & (rt == '0);
  assign is_bgez        = inst_bgez | inst_bgezal; // same sign test
  assign is_bltz        = inst_bltz | inst_bltzal;
  assign is_link_branch = inst_bgezal | inst_bltzal;
  assign is_j           = (op == `OP_J);
  assign is_jal         = (op == `OP_JAL);
  assign is_jr          = inst_jr_only | inst_jalr; // target from rs

  assign r_alu = inst_add | inst_addu | inst_sub | inst_subu | inst_slt | inst_sltu |
                 inst_and | inst_or | inst_xor | inst_nor |
                 inst_sll | inst_srl | inst_sra | inst_sllv | inst_srlv | inst_srav;
  assign i_alu = inst_addi | inst_addiu | inst_slti | inst_sltiu |
                 inst_andi | inst_ori | inst_xori | inst_lui;
  assign plain_branch = is_beq | is_bne | is_bgtz | is_blez | inst_bgez | inst_bltz;
  assign link_r31     = is_jal | is_link_branch; // implicit $31
  assign known   = r_alu | i_alu | inst_lw | inst_sw | plain_branch |
                   is_link_branch | is_j | is_jal | is_jr;
  assign uses_rt = r_alu | is_beq | is_bne | inst_sw; // sw reads rt as store data

  always_comb begin
    ctrl.alu_op[`ALU_ADD]  = inst_add | inst_addu | inst_addi | inst_addiu | inst_lw | inst_sw |
                             link_r31 | inst_jalr; // address and link sums
    ctrl.alu_op[`ALU_SUB]  = inst_sub | inst_subu;
    ctrl.alu_op[`ALU_SLT]  = inst_slt | inst_slti;
    ctrl.alu_op[`ALU_SLTU] = inst_sltu | inst_sltiu;
    ctrl.alu_op[`ALU_AND]  = inst_and | inst_andi;
    ctrl.alu_op[`ALU_NOR]  = inst_nor;
    ctrl.alu_op[`ALU_OR]   = inst_or | inst_ori;
    ctrl.alu_op[`ALU_XOR]  = inst_xor | inst_xori;
    ctrl.alu_op[`ALU_SLL]  = inst_sll | inst_sllv;
    ctrl.alu_op[`ALU_SRL]  = inst_srl | inst_srlv;
    ctrl.alu_op[`ALU_SRA]  = inst_sra | inst_srav;
    ctrl.alu_op[`ALU_LUI]  = inst_lui;
    ctrl.load_op      = inst_lw;
    ctrl.store_op     = inst_sw;
    ctrl.src1_is_sa   = inst_sll | inst_srl | inst_sra;
    ctrl.src1_is_pc   = link_r31 | inst_jalr;
    ctrl.src2_is_simm = inst_addi | inst_addiu | inst_slti | inst_sltiu | inst_lui |
                        inst_lw | inst_sw;
    ctrl.src2_is_zimm = inst_andi | inst_ori | inst_xori;
    ctrl.src2_is_8    = link_r31 | inst_jalr; // pc + 8 past the delay slot
    ctrl.gr_we        = known & ~inst_sw & ~plain_branch & ~is_j & ~inst_jr_only;
    ctrl.dest         = link_r31 ? 5'd31 : ((i_alu | inst_lw) ? rt : rd);
    ctrl.reserved     = ~known;
  end

endmodule

/* design/id_pipe_pkg.sv */
package id_pipe_pkg;
  import mips_isa_pkg::*;

  typedef struct packed {
    word_t pc;
    word_t inst;
  } fetch_bus_t; // fetch to decode, 64 bits

  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
  } wb_bus_t; // register write from write-back, 38 bits

  typedef struct packed {
    logic      valid;  // stage holds an item
    logic      gr_we;  // item writes a register
    reg_addr_t dest;
    word_t     result;
  } fwd_t; // pending write of a later stage, 39 bits

  typedef struct packed {
    fwd_t fwd;
    logic is_load; // result not ready until mem
  } exe_fwd_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } br_bus_t; // redirect to fetch

  typedef struct packed {
    alu_op_t   alu_op;
    logic      load_op;
    logic      store_op;
    logic      src1_is_sa;   // shamt as first operand
    logic      src1_is_pc;   // link address base
    logic      src2_is_simm; // sign-extended imm
    logic      src2_is_zimm; // zero-extended imm
    logic      src2_is_8;    // link offset
    logic      gr_we;
    reg_addr_t dest;
    logic      reserved;     // not a recognized instruction
  } ctrl_t;

  typedef struct packed {
    ctrl_t ctrl;
    imm_t  imm;
    word_t rs_value; // bypassed
    word_t rt_value; // bypassed
    word_t pc;
  } decode_bus_t; // decode to execute

endpackage

/* design/mips_isa_pkg.sv */
`include "mips_isa_consts.svh"

package mips_isa_pkg;

  typedef logic [31:0]           word_t;     // data word or pc
  typedef logic [4:0]            reg_addr_t; // register index
  typedef logic [5:0]            opcode_t;   // inst[31:26]
  typedef logic [5:0]            funct_t;    // inst[5:0]
  typedef logic [15:0]           imm_t;      // inst[15:0]
  typedef logic [`ALU_OP_W-1:0]  alu_op_t;   // one bit per alu function

endpackage

/* design/mips_isa_consts.svh */
`ifndef MIPS_ISA_CONSTS_SVH
`define MIPS_ISA_CONSTS_SVH

`define REG_COUNT 32 // general registers
`define NUM_SRC   2  // rs and rt
`define ALU_OP_W  12 // one-hot alu op width

// bit positions in the one-hot alu op
`define ALU_ADD   0
`define ALU_SUB   1
`define ALU_SLT   2
`define ALU_SLTU  3
`define ALU_AND   4
`define ALU_NOR   5
`define ALU_OR    6
`define ALU_XOR   7
`define ALU_SLL   8
`define ALU_SRL   9
`define ALU_SRA   10
`define ALU_LUI   11

`define OP_SPECIAL 6'h00 // r-type, op in funct
`define OP_REGIMM  6'h01 // bltz/bgez family, op in rt
`define OP_J       6'h02
`define OP_JAL     6'h03
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_BLEZ    6'h06
`define OP_BGTZ    6'h07
`define OP_ADDI    6'h08
`define OP_ADDIU   6'h09
`define OP_SLTI    6'h0a
`define OP_SLTIU   6'h0b
`define OP_ANDI    6'h0c
`define OP_ORI     6'h0d
`define OP_XORI    6'h0e
`define OP_LUI     6'h0f
`define OP_LW      6'h23
`define OP_SW      6'h2b

`define FN_SLL     6'h00
`define FN_SRL     6'h02
`define FN_SRA     6'h03
`define FN_SLLV    6'h04
`define FN_SRLV    6'h06
`define FN_SRAV    6'h07
`define FN_JR      6'h08
`define FN_JALR    6'h09
`define FN_ADD     6'h20
`define FN_ADDU    6'h21
`define FN_SUB     6'h22
`define FN_SUBU    6'h23
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_XOR     6'h26
`define FN_NOR     6'h27
`define FN_SLT     6'h2a
`define FN_SLTU    6'h2b

// regimm selectors, carried in the rt field
`define RI_BLTZ    5'h00
`define RI_BGEZ    5'h01
`define RI_BLTZAL  5'h10
`define RI_BGEZAL  5'h11

`endif
